/* list.f */
+incdir+rtl
rtl/noc_types_pkg.sv
rtl/arb_ctrl_pkg.sv
rtl/input_port_ctrl.sv
rtl/rr_output_alloc.sv
rtl/grant_collector.sv
rtl/router_arbiter.sv
test/arb_checker.sv
test/tb_router_arbiter.sv

/* rtl/arb_ctrl_pkg.sv */
package arb_ctrl_pkg;

	import noc_types_pkg::*;

	// input port controller states
	typedef enum logic [1:0] {
		IN_IDLE = 2'd0,
		IN_REQ  = 2'd1,   // waiting for a grant
		IN_SEND = 2'd2    // packet in flight
	} in_state_e;

	// one input's request toward the allocators
	typedef struct packed {
		logic      valid;
		port_dir_e dst;
	} port_req_t;

	// one output's current owner
	typedef struct packed {
		logic      valid;
		port_dir_e src;
	} out_grant_t;

endpackage

/* rtl/arb_params.svh */
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// router ports N, S, W, E, L
`define ARB_NUM_PORTS 5

// bits per mesh coordinate
`define ARB_COORD_W 4

// fixed packet length in flits
`define ARB_PKT_FLITS 4

`endif

/* rtl/grant_collector.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module grant_collector
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
(
	input  logic                      clk,
	input  out_grant_t                grant_i [`ARB_NUM_PORTS],
	input  logic [`ARB_NUM_PORTS-1:0] ib_empty_i,
	output logic [`ARB_NUM_PORTS-1:0] flit_read_o,
	output logic [`ARB_NUM_PORTS-1:0] ib_read_o,
	output port_dir_e                 xbar_sel_o [`ARB_NUM_PORTS]
);

	logic [`ARB_NUM_PORTS-1:0][`ARB_NUM_PORTS-1:0] hold_map;   // [input][output]
	logic [`ARB_NUM_PORTS-1:0]                     held;
	logic [`ARB_NUM_PORTS-1:0]                     read_strobe;

	// invert output->input grants
	always_comb begin
		for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
			for (int o = 0; o < `ARB_NUM_PORTS; o++) begin
				hold_map[k][o] = grant_i[o].valid && (int'(grant_i[o].src) == k);
			end
			held[k] = |hold_map[k];
		end
	end

	assign read_strobe = held & ~ib_empty_i;   // stall on empty buffer
	assign flit_read_o = read_strobe;
	assign ib_read_o   = read_strobe;

	always_comb begin
		for (int o = 0; o < `ARB_NUM_PORTS; o++) begin
			xbar_sel_o[o] = grant_i[o].valid ? grant_i[o].src : DIR_NONE;
		end
	end

	// allocators run independently, yet an input may feed only one output
	for (genvar k = 0; k < `ARB_NUM_PORTS; k++) begin : g_one_owner
		assert property (@(posedge clk) $onehot0(hold_map[k]));
	end

endmodule

/* rtl/input_port_ctrl.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module input_port_ctrl
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  node_addr_t router_addr_i,
	input  node_addr_t hdr_addr_i,
	input  logic       ib_empty_i,
	input  logic       flit_read_i,
	output port_req_t  req_o
);

	localparam int CNT_W = $clog2(`ARB_PKT_FLITS + 1);

	in_state_e        state_q;
	logic [CNT_W-1:0] flit_cnt_q;
	port_req_t        req_q;
	port_dir_e        route;
	logic             last_flit;

	// YX routing, y resolved first
	always_comb begin
		if (hdr_addr_i.y > router_addr_i.y) begin
			route = DIR_S;
		end else if (hdr_addr_i.y < router_addr_i.y) begin
			route = DIR_N;
		end else if (hdr_addr_i.x > router_addr_i.x) begin
			route = DIR_E;
		end else if (hdr_addr_i.x < router_addr_i.x) begin
			route = DIR_W;
		end else begin
			route = DIR_L;   // header addresses this node
		end
	end

	assign last_flit = (flit_cnt_q == CNT_W'(`ARB_PKT_FLITS - 1));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= IN_IDLE;
			flit_cnt_q <= '0;
			req_q.valid <= 1'b0;
			req_q.dst   <= DIR_NONE;
		end else begin
			case (state_q)
				IN_IDLE: begin
					if (!ib_empty_i) begin   // header at buffer head
						state_q     <= IN_REQ;
						req_q.valid <= 1'b1;
						req_q.dst   <= route;
					end
				end
				IN_REQ, IN_SEND: begin
					if (flit_read_i) begin
						if (last_flit) begin   // packet done, drop request
							state_q     <= IN_IDLE;
							flit_cnt_q  <= '0;
							req_q.valid <= 1'b0;
							req_q.dst   <= DIR_NONE;
						end else begin
							state_q    <= IN_SEND;
							flit_cnt_q <= flit_cnt_q + 1'b1;
						end
					end
				end
				default: begin
					state_q <= IN_IDLE;
				end
			endcase
		end
	end

	assign req_o = req_q;

	// an idle input has no request, so no allocator may be reading it
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(state_q == IN_IDLE) |-> !flit_read_i);

endmodule

/* rtl/noc_types_pkg.sv */
`include "arb_params.svh"

package noc_types_pkg;

	// port index and crossbar select share one encoding
	typedef enum logic [2:0] {
		DIR_N    = 3'd0,
		DIR_S    = 3'd1,
		DIR_W    = 3'd2,
		DIR_E    = 3'd3,
		DIR_L    = 3'd4,   // local core
		DIR_NONE = 3'd7    // no connection
	} port_dir_e;

	// mesh node address, y in the upper half
	typedef struct packed {
		logic [`ARB_COORD_W-1:0] y;
		logic [`ARB_COORD_W-1:0] x;
	} node_addr_t;

endpackage

/* rtl/router_arbiter.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module router_arbiter
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  node_addr_t                router_addr_i,
	input  node_addr_t                hdr_addr_i [`ARB_NUM_PORTS],
	input  logic [`ARB_NUM_PORTS-1:0] ib_empty_i,
	output logic [`ARB_NUM_PORTS-1:0] ib_read_o,
	output port_dir_e                 xbar_sel_o [`ARB_NUM_PORTS]
);

	port_req_t                 req_w [`ARB_NUM_PORTS];   // input -> all allocators
	out_grant_t                grant_w [`ARB_NUM_PORTS];
	logic [`ARB_NUM_PORTS-1:0] flit_read_w;

	input_port_ctrl u_in_n (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i[DIR_N]), .ib_empty_i(ib_empty_i[DIR_N]),
		.flit_read_i(flit_read_w[DIR_N]), .req_o(req_w[DIR_N])
	);

	input_port_ctrl u_in_s (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i[DIR_S]), .ib_empty_i(ib_empty_i[DIR_S]),
		.flit_read_i(flit_read_w[DIR_S]), .req_o(req_w[DIR_S])
	);

	input_port_ctrl u_in_w (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i[DIR_W]), .ib_empty_i(ib_empty_i[DIR_W]),
		.flit_read_i(flit_read_w[DIR_W]), .req_o(req_w[DIR_W])
	);

	input_port_ctrl u_in_e (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i[DIR_E]), .ib_empty_i(ib_empty_i[DIR_E]),
		.flit_read_i(flit_read_w[DIR_E]), .req_o(req_w[DIR_E])
	);

	input_port_ctrl u_in_l (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i[DIR_L]), .ib_empty_i(ib_empty_i[DIR_L]),
		.flit_read_i(flit_read_w[DIR_L]), .req_o(req_w[DIR_L])
	);

	// one allocator per output
	rr_output_alloc #(.OUT_DIR(DIR_N)) u_out_n (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req_w), .grant_o(grant_w[DIR_N])
	);

	rr_output_alloc #(.OUT_DIR(DIR_S)) u_out_s (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req_w), .grant_o(grant_w[DIR_S])
	);

	rr_output_alloc #(.OUT_DIR(DIR_W)) u_out_w (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req_w), .grant_o(grant_w[DIR_W])
	);

	rr_output_alloc #(.OUT_DIR(DIR_E)) u_out_e (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req_w), .grant_o(grant_w[DIR_E])
	);

	rr_output_alloc #(.OUT_DIR(DIR_L)) u_out_l (
		.clk(clk), .rst_n_i(rst_n_i), .req_i(req_w), .grant_o(grant_w[DIR_L])
	);

	grant_collector u_collect (
		.clk(clk),
		.grant_i(grant_w),
		.ib_empty_i(ib_empty_i),
		.flit_read_o(flit_read_w),
		.ib_read_o(ib_read_o),
		.xbar_sel_o(xbar_sel_o)
	);

endmodule

/* rtl/rr_output_alloc.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module rr_output_alloc
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
#(
	parameter port_dir_e OUT_DIR = DIR_N
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  port_req_t  req_i [`ARB_NUM_PORTS],
	output out_grant_t grant_o
);

	logic [`ARB_NUM_PORTS-1:0] want;
	out_grant_t                lock_q;
	port_dir_e                 last_q;
	logic                      pick_valid;
	port_dir_e                 pick_dir;
	logic                      owner_live;

	// requests aimed at this output
	always_comb begin
		for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
			want[i] = req_i[i].valid && (req_i[i].dst == OUT_DIR);
		end
	end

	// search starts one past the last winner
	always_comb begin : search
		int idx;
		pick_valid = 1'b0;
		pick_dir   = DIR_NONE;
		for (int i = 1; i <= `ARB_NUM_PORTS; i++) begin
			idx = (int'(last_q) + i) % `ARB_NUM_PORTS;
			if (!pick_valid && want[idx]) begin
				pick_valid = 1'b1;
				pick_dir   = port_dir_e'(3'(idx));
			end
		end
	end

	// owner still requesting
	assign owner_live = lock_q.valid && req_i[lock_q.src].valid;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lock_q.valid <= 1'b0;
			lock_q.src   <= DIR_NONE;
			last_q       <= DIR_L;   // first search begins at N
		end else if (lock_q.valid) begin
			if (!owner_live) begin   // packet finished
				lock_q.valid <= 1'b0;
				lock_q.src   <= DIR_NONE;
			end
		end else if (pick_valid) begin
			lock_q.valid <= 1'b1;
			lock_q.src   <= pick_dir;
			last_q       <= pick_dir;
		end
	end

	// the cycle after the last flit the lock is still set but
	// the owner has already dropped its request, so no read must follow
	assign grant_o.valid = owner_live;
	assign grant_o.src   = owner_live ? lock_q.src : DIR_NONE;

	// owner keeps its route to this output for the whole packet
	assert property (@(posedge clk) disable iff (!rst_n_i)
		owner_live |-> (req_i[lock_q.src].dst == OUT_DIR));

	// a fresh lock always lands on a live request
	assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(lock_q.valid) |-> owner_live);

endmodule

/* test/arb_checker.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module arb_checker
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  node_addr_t                router_addr_i,
	input  node_addr_t                hdr_addr_i [`ARB_NUM_PORTS],
	input  logic [`ARB_NUM_PORTS-1:0] ib_empty_i,
	input  logic [`ARB_NUM_PORTS-1:0] ib_read_o,
	input  port_dir_e                 xbar_sel_o [`ARB_NUM_PORTS]
);

	int        exp_port_q [`ARB_NUM_PORTS][$];   // filled by the testbench
	int        exp_id_q [`ARB_NUM_PORTS][$];
	int        err_cnt = 0;
	int        done_cnt = 0;
	int        par_cycles = 0;
	int        flit_cnt [`ARB_NUM_PORTS];
	bit        busy [`ARB_NUM_PORTS];
	bit        pkt_err [`ARB_NUM_PORTS];
	int        last_owner [`ARB_NUM_PORTS];
	int        wait_cnt [`ARB_NUM_PORTS];
	int        wait_route [`ARB_NUM_PORTS];
	port_dir_e prev_sel [`ARB_NUM_PORTS];

	function automatic int yx_route(node_addr_t here, node_addr_t dst);
		if (dst.y != here.y) begin
			return (dst.y > here.y) ? 1 : 0;   // S or N
		end
		if (dst.x != here.x) begin
			return (dst.x > here.x) ? 3 : 2;   // E or W
		end
		return 4;
	endfunction

	task automatic mismatch(int k, string sig, int exp_v, int got_v);
		$display("MISMATCH t=%0t %s expected=%0d got=%0d", $time, sig, exp_v, got_v);
		err_cnt++;
		if (k >= 0) begin
			pkt_err[k] = 1'b1;
		end
	endtask

	task automatic fail_note(string what);
		$display("ERROR t=%0t %s", $time, what);
		err_cnt++;
	endtask

	task automatic end_packet(int k);
		int id;
		if (flit_cnt[k] != `ARB_PKT_FLITS) begin
			mismatch(k, $sformatf("read pulses of input %0d", k), `ARB_PKT_FLITS, flit_cnt[k]);
		end
		if (exp_id_q[k].size() == 0) begin
			fail_note($sformatf("input %0d sent a packet that is not in the stimulus", k));
		end else begin
			id = exp_id_q[k].pop_front();
			void'(exp_port_q[k].pop_front());
			$display("test %0d: input %0d %s", id, k, pkt_err[k] ? "FAIL" : "ok");
		end
		done_cnt++;
		busy[k]     = 1'b0;
		flit_cnt[k] = 0;
		pkt_err[k]  = 1'b0;
	endtask

	task automatic new_owner(int o, int k);
		int want;
		int idx;
		want = -1;
		for (int i = 1; i <= `ARB_NUM_PORTS; i++) begin
			idx = (last_owner[o] + i) % `ARB_NUM_PORTS;
			if (want < 0 && wait_cnt[idx] >= 2 && wait_route[idx] == o) begin
				want = idx;
			end
		end
		if (want != k) begin
			mismatch(k, $sformatf("owner of xbar_sel_o[%0d]", o), want, k);
		end
		last_owner[o] = k;
		busy[k]       = 1'b1;
	endtask

	always @(posedge clk) begin : watch
		int nsel;
		int hits;
		int found;
		int owner;
		if (!rst_n_i) begin
			for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
				if (xbar_sel_o[i] != DIR_NONE) begin
					mismatch(-1, $sformatf("xbar_sel_o[%0d]", i), DIR_NONE, xbar_sel_o[i]);
				end
				flit_cnt[i]   = 0;
				busy[i]       = 0;
				pkt_err[i]    = 0;
				last_owner[i] = 4;   // search starts at N
				wait_cnt[i]   = 0;
				wait_route[i] = -1;
				prev_sel[i]   = DIR_NONE;
			end
			if (ib_read_o != '0) begin
				mismatch(-1, "ib_read_o", 0, ib_read_o);
			end
		end else begin
			nsel = 0;
			for (int o = 0; o < `ARB_NUM_PORTS; o++) begin
				if (xbar_sel_o[o] != DIR_NONE) nsel++;
				if (prev_sel[o] != DIR_NONE && xbar_sel_o[o] != prev_sel[o]) begin
					end_packet(int'(prev_sel[o]));
					if (xbar_sel_o[o] != DIR_NONE) begin
						fail_note($sformatf("output %0d changed owner without release", o));
					end
				end
				if (xbar_sel_o[o] != DIR_NONE && xbar_sel_o[o] != prev_sel[o]) begin
					new_owner(o, int'(xbar_sel_o[o]));
				end
			end
			if (nsel >= 2) par_cycles++;
			for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
				if (ib_read_o[k]) begin
					if (ib_empty_i[k]) begin
						mismatch(k, $sformatf("ib_empty_i[%0d] at read", k), 0, 1);
					end
					hits = 0;
					found = -1;
					for (int o = 0; o < `ARB_NUM_PORTS; o++) begin
						if (xbar_sel_o[o] == k) begin
							hits++;
							found = o;
						end
					end
					if (hits != 1) begin
						mismatch(k, $sformatf("selects naming input %0d", k), 1, hits);
					end else begin
						if (found != yx_route(router_addr_i, hdr_addr_i[k])) begin
							mismatch(k, $sformatf("route of input %0d", k),
								yx_route(router_addr_i, hdr_addr_i[k]), found);
						end
						if (exp_port_q[k].size() > 0 && found != exp_port_q[k][0]) begin
							mismatch(k, $sformatf("output of input %0d", k),
								exp_port_q[k][0], found);
						end
					end
					flit_cnt[k]++;
				end
			end
			// all buffers empty, only a packet stalled midway may hold a select
			if (&ib_empty_i) begin
				for (int o = 0; o < `ARB_NUM_PORTS; o++) begin
					owner = int'(xbar_sel_o[o]);
					if (xbar_sel_o[o] != DIR_NONE && (owner >= `ARB_NUM_PORTS ||
						flit_cnt[owner] == 0 || flit_cnt[owner] >= `ARB_PKT_FLITS)) begin
						mismatch(-1, $sformatf("xbar_sel_o[%0d] while idle", o),
							DIR_NONE, owner);
					end
				end
			end
			for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
				if (!ib_empty_i[k] && !busy[k]) begin   // idle and holding a header
					wait_cnt[k]++;
					wait_route[k] = yx_route(router_addr_i, hdr_addr_i[k]);
				end else begin
					wait_cnt[k] = 0;
				end
				prev_sel[k] = xbar_sel_o[k];
			end
		end
	end

	task automatic final_report();
		for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
			if (exp_id_q[k].size() != 0) begin
				fail_note($sformatf("input %0d left %0d packets unsent", k, exp_id_q[k].size()));
			end
		end
		if (par_cycles == 0) begin
			fail_note("no two packets ever ran at the same time");
		end
		$display("packets done %0d, parallel cycles %0d, errors %0d", done_cnt, par_cycles, err_cnt);
	endtask

endmodule

/* test/arb_stim.txt */
// one packet per line, router sits at y=2 x=2
// test id, input port, dest y, dest x, idle gap before packet, expected output port
00 0 3 1 00 1
01 1 0 2 00 0
02 2 2 4 00 3
03 3 2 0 00 2
04 4 2 2 00 4
05 0 4 4 02 1
06 2 5 0 00 1
07 3 7 2 00 1
08 4 3 3 00 1
09 0 2 2 00 4
0a 1 2 2 00 4
0b 2 2 2 01 4
0c 3 2 2 00 4
0d 4 0 0 03 0
0e 1 1 5 02 0
0f 0 2 9 00 3
10 2 2 1 04 2
11 3 f f 00 1
12 4 2 3 01 3
13 1 2 2 00 4
14 0 0 2 05 0
15 2 2 2 00 4
16 3 1 1 02 0
17 4 2 0 00 2

/* test/tb_router_arbiter.sv */
`timescale 1ns/1ps

`include "arb_params.svh"

module tb_router_arbiter
	import noc_types_pkg::*;
	import arb_ctrl_pkg::*;
();

	localparam int MAX_ROWS = 64;
	localparam int TIMEOUT  = 2000;

	logic                      clk;
	logic                      rst_n_i;
	node_addr_t                router_addr_i;
	node_addr_t                hdr_addr_i [`ARB_NUM_PORTS];
	logic [`ARB_NUM_PORTS-1:0] ib_empty_i;
	logic [`ARB_NUM_PORTS-1:0] ib_read_o;
	port_dir_e                 xbar_sel_o [`ARB_NUM_PORTS];

	logic [7:0]  stim_mem [0:MAX_ROWS*6-1];
	int          pkt_q [`ARB_NUM_PORTS][$];   // row numbers per input buffer
	int          flits_left [`ARB_NUM_PORTS];
	int          gap_cnt [`ARB_NUM_PORTS];
	bit          stall_pkt [`ARB_NUM_PORTS];
	logic [31:0] rng = 32'h98dd;
	int          total = 0;
	int          cyc;

	router_arbiter router_arbiter_inst (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i), .ib_empty_i(ib_empty_i),
		.ib_read_o(ib_read_o), .xbar_sel_o(xbar_sel_o)
	);

	arb_checker arb_checker_inst (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.hdr_addr_i(hdr_addr_i), .ib_empty_i(ib_empty_i),
		.ib_read_o(ib_read_o), .xbar_sel_o(xbar_sel_o)
	);

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	always #2 clk = ~clk;

	// input buffer model
	always @(posedge clk) begin
		if (rst_n_i) begin
			rng = xorshift(rng);
			for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
				if (flits_left[k] > 0 && ib_read_o[k]) begin
					flits_left[k]--;
					if (flits_left[k] == 0) begin
						void'(pkt_q[k].pop_front());
						if (pkt_q[k].size() > 0) gap_cnt[k] = stim_mem[pkt_q[k][0]*6+4];
					end
				end
				if (flits_left[k] > 0) begin
					// stall only after the header flit is gone
					ib_empty_i[k] <= stall_pkt[k] && flits_left[k] < `ARB_PKT_FLITS && rng[k+8];
				end else if (pkt_q[k].size() > 0 && gap_cnt[k] > 0) begin
					gap_cnt[k]--;
					ib_empty_i[k] <= 1'b1;
				end else if (pkt_q[k].size() > 0) begin
					flits_left[k] = `ARB_PKT_FLITS;
					stall_pkt[k]  = rng[k];
					hdr_addr_i[k] <= {stim_mem[pkt_q[k][0]*6+2][3:0], stim_mem[pkt_q[k][0]*6+3][3:0]};
					ib_empty_i[k] <= 1'b0;
				end else begin
					ib_empty_i[k] <= 1'b1;
				end
			end
		end
	end

	initial begin
		int p;
		clk           = 1'b0;
		rst_n_i       = 1'b0;
		router_addr_i = 8'h22;
		ib_empty_i    = '1;
		for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
			hdr_addr_i[k] = '0;
			flits_left[k] = 0;
			gap_cnt[k]    = 0;
			stall_pkt[k]  = 1'b0;
		end
		$readmemh("test/arb_stim.txt", stim_mem);
		for (int r = 0; r < MAX_ROWS && !$isunknown(stim_mem[r*6]); r++) begin
			p = stim_mem[r*6+1];
			pkt_q[p].push_back(r);
			arb_checker_inst.exp_id_q[p].push_back(stim_mem[r*6]);
			arb_checker_inst.exp_port_q[p].push_back(stim_mem[r*6+5]);
			total++;
		end
		for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
			if (pkt_q[k].size() > 0) gap_cnt[k] = stim_mem[pkt_q[k][0]*6+4];
		end
		for (int c = 0; c < 10; c++) @(posedge clk);
		rst_n_i <= 1'b1;
		cyc = 0;
		while (arb_checker_inst.done_cnt < total && cyc < TIMEOUT) begin
			@(posedge clk);
			cyc++;
		end
		if (cyc >= TIMEOUT) begin
			$display("timeout: %0d of %0d packets finished", arb_checker_inst.done_cnt, total);
			$display("Simulation failed");
			$finish;
		end else begin
			for (int c = 0; c < 4; c++) @(posedge clk);   // idle tail
			arb_checker_inst.final_report();
			if (arb_checker_inst.err_cnt == 0) begin
				$display("Simulation passed");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule
